// ==== uart_pkg.sv ====
package uart_pkg;

  // serial timing, scaled down for simulation
  localparam int clks_per_bit = 8;
  localparam int frame_bits = 11;

  localparam int fifo_depth = 4;

  // 0 leaves parity_err at zero
  localparam bit rx_parity_check = 1'b1;

  // derived widths
  localparam int baud_cnt_w = $clog2(clks_per_bit);
  localparam int bit_cnt_w = $clog2(frame_bits);
  localparam int fifo_ptr_w = $clog2(fifo_depth);

  // sent as two bytes, {rd_flag, addr} first and data second
  typedef struct packed {
    logic       rd_flag;
    logic [6:0] addr;
    logic [7:0] data;
  } cmd_t;

  // last marks the second byte of a command
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } tx_byte_t;

  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       frame_err;
  } rx_result_t;

endpackage

// ==== tx_fifo.sv ====
`timescale 1ns/1ns

module tx_fifo
  import uart_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     wr_en,
  input  tx_byte_t wr_data,
  output logic     full,
  input  logic     rd_en,
  output tx_byte_t rd_data,
  output logic     empty
);

  tx_byte_t mem [fifo_depth];

  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_ptr_w:0]   count;
  logic [fifo_ptr_w:0]   count_nxt;
  logic                  do_wr;
  logic                  do_rd;

  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // head entry, no read latency
  assign rd_data = mem[rd_ptr];

  always_comb begin
    case ({do_wr, do_rd})
      2'b10:   count_nxt = count + 1'b1;
      2'b01:   count_nxt = count - 1'b1;
      default: count_nxt = count;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      count <= count_nxt;
      full  <= (count_nxt == (fifo_ptr_w + 1)'(fifo_depth));
      empty <= (count_nxt == '0);
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule

// ==== cmd_splitter.sv ====
`timescale 1ns/1ns

module cmd_splitter
  import uart_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  cmd_t     cmd,
  input  logic     cmd_vld,
  output logic     cmd_rdy,
  input  logic     full,
  output logic     wr_en,
  output tx_byte_t wr_data
);

  typedef enum logic [1:0] {
    st_idle,
    st_hi,
    st_lo
  } state_t;

  state_t state;
  cmd_t   cmd_q;

  assign cmd_rdy = (state == st_idle);

  // a full FIFO holds the write in place
  assign wr_en = (state != st_idle) && !full;

  always_comb begin
    if (state == st_lo) begin
      wr_data = '{data: cmd_q.data, last: 1'b1};
    end else begin
      wr_data = '{data: {cmd_q.rd_flag, cmd_q.addr}, last: 1'b0};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (cmd_vld) state <= st_hi;
        st_hi:   if (!full) state <= st_lo;
        st_lo:   if (!full) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_vld && cmd_rdy) begin
      cmd_q <= cmd;
    end
  end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx
  import uart_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     empty,
  input  tx_byte_t rd_data,
  output logic     rd_en,
  output logic     tx
);

  logic                  busy;
  logic [baud_cnt_w-1:0] baud_cnt;
  logic [bit_cnt_w-1:0]  bit_cnt;
  logic [frame_bits-1:0] shift_q;
  logic                  baud_last;

  // pop only from idle, so frames are always one cycle apart
  assign rd_en = !busy && !empty;

  assign baud_last = (baud_cnt == baud_cnt_w'(clks_per_bit - 1));

  // shift register fills with ones, so tx idles high
  assign tx = shift_q[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      shift_q  <= '1;
    end else if (rd_en) begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      // stop, odd parity, data lsb first, start
      shift_q  <= {1'b1, ~^rd_data.data, rd_data.data, 1'b0};
    end else if (busy) begin
      if (baud_last) begin
        baud_cnt <= '0;
        shift_q  <= {1'b1, shift_q[frame_bits-1:1]};
        if (bit_cnt == bit_cnt_w'(frame_bits - 1)) begin
          busy <= 1'b0;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output rx_result_t read_data,
  output logic       read_rdy
);

  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_parity,
    rx_stop
  } rx_state_t;

  rx_state_t             state;
  logic                  rx_meta;
  logic                  rx_sync;
  logic                  rx_prev;
  logic [baud_cnt_w-1:0] baud_cnt;
  logic [2:0]            bit_idx;
  logic [7:0]            data_q;
  logic                  par_q;
  logic                  start_fall;
  logic                  half_tick;
  logic                  bit_tick;

  assign start_fall = rx_prev && !rx_sync;
  assign half_tick  = (baud_cnt == baud_cnt_w'(clks_per_bit / 2 - 1));
  // one full bit after mid-start lands mid-bit
  assign bit_tick   = (baud_cnt == baud_cnt_w'(clks_per_bit - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= rx_idle;
      baud_cnt <= '0;
      bit_idx  <= '0;
      read_rdy <= 1'b0;
    end else begin
      read_rdy <= 1'b0;
      case (state)
        rx_idle: begin
          baud_cnt <= '0;
          if (start_fall) state <= rx_start;
        end
        rx_start: begin
          if (half_tick) begin
            baud_cnt <= '0;
            bit_idx  <= '0;
            // glitch rather than start bit
            state    <= rx_sync ? rx_idle : rx_data;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        rx_data: begin
          if (bit_tick) begin
            baud_cnt <= '0;
            if (bit_idx == 3'd7) state <= rx_parity;
            else bit_idx <= bit_idx + 1'b1;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        rx_parity: begin
          if (bit_tick) begin
            baud_cnt <= '0;
            state    <= rx_stop;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        rx_stop: begin
          if (bit_tick) begin
            state    <= rx_idle;
            read_rdy <= 1'b1;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == rx_data && bit_tick) data_q <= {rx_sync, data_q[7:1]};
    if (state == rx_parity && bit_tick) par_q <= rx_sync;
    if (state == rx_stop && bit_tick) begin
      read_data.data       <= data_q;
      // odd parity over data and parity bit
      read_data.parity_err <= rx_parity_check && !(^{data_q, par_q});
      read_data.frame_err  <= !rx_sync;
    end
  end

endmodule

// ==== uart_cmd_top.sv ====
`timescale 1ns/1ns

module uart_cmd_top
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  cmd_t       cmd,
  input  logic       cmd_vld,
  output logic       cmd_rdy,
  output logic       tx,
  input  logic       rx,
  output rx_result_t read_data,
  output logic       read_rdy
);

  logic     wr_en;
  tx_byte_t wr_data;
  logic     full;
  logic     rd_en;
  tx_byte_t rd_data;
  logic     empty;

  cmd_splitter u_splitter (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd     (cmd),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .full    (full),
    .wr_en   (wr_en),
    .wr_data (wr_data)
  );

  tx_fifo u_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (wr_en),
    .wr_data (wr_data),
    .full    (full),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .empty   (empty)
  );

  uart_tx u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .empty   (empty),
    .rd_data (rd_data),
    .rd_en   (rd_en),
    .tx      (tx)
  );

  // receive path runs independently of the command chain
  uart_rx u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

endmodule

// ==== uart_cmd_chk.sv ====
`timescale 1ns/1ns

module uart_cmd_chk (
  input logic clk,
  input logic rst_n,
  input logic tx,
  input logic tx_busy,
  input logic wr_en,
  input logic wr_last,
  input logic full,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic read_rdy
);

  // line sits high between frames
  assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> tx)
    else $error("tx low while transmitter idle");

  // ready again only once the low byte went in
  assert property (@(posedge clk) disable iff (!rst_n)
                   $rose(cmd_rdy) |-> $past(wr_en && wr_last))
    else $error("cmd_rdy rose without a low byte write");

  assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
    else $error("read_rdy high for two cycles");

  // splitter busy after acceptance and while stalled
  assert property (@(posedge clk) disable iff (!rst_n) (cmd_vld && cmd_rdy) |=> !cmd_rdy)
    else $error("cmd_rdy high right after acceptance");

  assert property (@(posedge clk) disable iff (!rst_n) (!cmd_rdy && full) |=> !cmd_rdy)
    else $error("cmd_rdy rose while FIFO full");

endmodule

bind uart_cmd_top uart_cmd_chk u_chk (
  .clk      (clk),
  .rst_n    (rst_n),
  .tx       (tx),
  .tx_busy  (u_tx.busy),
  .wr_en    (wr_en),
  .wr_last  (wr_data.last),
  .full     (full),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .read_rdy (read_rdy)
);

// ==== tb_uart_cmd.sv ====
`timescale 1ns/1ns

module tb_uart_cmd
  import uart_pkg::*;
();

  logic       clk = 1'b0;
  logic       rst_n;
  cmd_t       cmd;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       tx;
  logic       rx;
  rx_result_t read_data;
  logic       read_rdy;

  logic [7:0]  exp_q[$];
  logic [9:0]  got_q[$];
  logic [9:0]  rx_exp_q[$];
  logic [10:0] mon_bits;
  int          val_errs = 0;
  int          other_errs = 0;
  int          cycle_cnt = 0;
  int          max_wait = 0;

  uart_cmd_top u_dut (.*);

  always #2 clk = ~clk;

  // data, odd parity and stop bit of one frame
  function automatic logic [9:0] expected_frame(input logic [7:0] b);
    logic par;
    // ones in data and parity bit add up odd
    par = ($countones(b) % 2 == 0);
    return {1'b1, par, b};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    other_errs++;
  endtask

  task automatic finish_run();
    $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  // hold keeps cmd_vld up until the command is taken
  task automatic drive_cmd(input cmd_t c, input logic hold, output logic taken);
    int waits;
    waits = 0;
    @(posedge clk);
    cmd <= c;
    cmd_vld <= 1'b1;
    do begin
      @(negedge clk);
      taken = cmd_rdy;
      @(posedge clk);
      waits++;
    end while (hold && !taken);
    cmd_vld <= 1'b0;
    if (waits > max_wait) max_wait = waits;
    if (taken) begin
      exp_q.push_back({c.rd_flag, c.addr});
      exp_q.push_back(c.data);
    end
  endtask

  // remote transmitter
  task automatic send_rx(input logic [7:0] b, input logic bad_par, input logic bad_stop);
    logic [9:0]  f;
    logic [10:0] bits;
    f = expected_frame(b);
    bits = {f[9] ^ bad_stop, f[8] ^ bad_par, b, 1'b0};
    rx_exp_q.push_back({b, bad_par & rx_parity_check, bad_stop});
    repeat (frame_bits) begin
      @(posedge clk);
      rx <= bits[0];
      bits = bits >> 1;
      repeat (clks_per_bit - 1) @(posedge clk);
    end
    @(posedge clk);
    rx <= 1'b1;
    repeat (2 * clks_per_bit) @(posedge clk);
  endtask

  task automatic wait_drain();
    int guard;
    guard = 0;
    while ((exp_q.size() > 0 || rx_exp_q.size() > 0) && guard < 5000) begin
      @(negedge clk);
      guard++;
    end
    // room for a stray frame to show up
    repeat (frame_bits * clks_per_bit + clks_per_bit) @(negedge clk);
  endtask

  // remote receiver, samples each bit at its middle
  always begin
    @(negedge tx);
    repeat (clks_per_bit / 2) @(negedge clk);
    mon_bits = {tx, 10'b0};
    repeat (frame_bits - 1) begin
      repeat (clks_per_bit) @(negedge clk);
      mon_bits = {tx, mon_bits[10:1]};
    end
    if (mon_bits[0] !== 1'b0) report_failure("tx start bit not low at mid-bit");
    got_q.push_back(mon_bits[10:1]);
  end

  always @(negedge clk) begin
    if (got_q.size() > 0) begin
      if (exp_q.size() == 0) begin
        report_failure("tx frame with no accepted command behind it");
        got_q.delete(0);
      end else begin
        check_value("tx frame", 32'(got_q.pop_front()),
                    32'(expected_frame(exp_q.pop_front())));
      end
    end
  end

  always @(negedge clk) begin
    if (read_rdy === 1'b1) begin
      if (rx_exp_q.size() == 0) report_failure("spurious read_rdy with no frame driven");
      else check_value("read_data", 32'(read_data), 32'(rx_exp_q.pop_front()));
    end
  end

  // about 60 frames of 88 cycles plus the rx frames, with margin
  initial begin
    while (cycle_cnt < 10000) begin
      @(posedge clk);
      cycle_cnt++;
    end
    report_failure("timeout, run did not finish within 10000 cycles");
    finish_run();
  end

  initial begin
    cmd_t c;
    logic taken;
    void'($urandom(13));
    rst_n = 1'b0;
    cmd = '0;
    cmd_vld = 1'b0;
    rx = 1'b1;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    drive_cmd(16'h3a5c, 1'b1, taken);
    wait_drain();
    // every third one a read
    for (int i = 0; i < 20; i++) begin
      c = cmd_t'(16'($urandom));
      c.rd_flag = (i % 3 == 0);
      drive_cmd(c, 1'b1, taken);
    end
    wait_drain();
    // stray strobe right after each accepted command
    max_wait = 0;
    for (int i = 0; i < 8; i++) begin
      drive_cmd(cmd_t'(16'($urandom)), 1'b1, taken);
      drive_cmd(16'hffff, 1'b0, taken);
    end
    wait_drain();
    if (max_wait < clks_per_bit) report_failure("cmd_rdy never held low by a full FIFO");
    for (int i = 0; i < 4; i++) send_rx(8'($urandom), 1'b0, 1'b0);
    send_rx(8'h96, 1'b1, 1'b0);
    send_rx(8'h41, 1'b0, 1'b1);
    send_rx(8'h7e, 1'b0, 1'b0);
    wait_drain();
    if (exp_q.size() > 0) report_failure("tx frames missing at end of run");
    if (rx_exp_q.size() > 0) report_failure("read_rdy missing for a driven rx frame");
    finish_run();
  end

endmodule

// ==== build.f ====
uart_pkg.sv
tx_fifo.sv
cmd_splitter.sv
uart_tx.sv
uart_rx.sv
uart_cmd_top.sv
uart_cmd_chk.sv
tb_uart_cmd.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the UART command link testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_uart_cmd -o sim_uart_cmd
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/sim_uart_cmd > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$log"; then
  exit 1
fi
exit 0
